/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

	localparam int xlen    = 64;
	localparam int shamt_w = 6;

	typedef logic [xlen-1:0] xlen_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [31:0]     inst_t;

	// major opcodes handled by the core
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 bit 5, i.e. instruction bit 30, marks SUB and SRA
	localparam int         F7_ALT_BIT = 5;
	localparam logic [6:0] F7_BASE    = 7'b0000000;
	localparam logic [6:0] F7_ALT     = 7'b0100000;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm12;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} i_type_t;

	// one instruction word, two field layouts
	typedef union packed {
		r_type_t r;
		i_type_t i;
	} inst_u;

endpackage

/* source/rv_pipe_pkg.sv */
package rv_pipe_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	// decode to execute
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		logic                  use_imm;
		alu_op_e               alu_op;
		rv_isa_pkg::reg_addr_t rs1_addr;
		rv_isa_pkg::reg_addr_t rs2_addr;
		rv_isa_pkg::xlen_t     rs1_data;
		rv_isa_pkg::xlen_t     rs2_data;
		rv_isa_pkg::xlen_t     imm;
		rv_isa_pkg::reg_addr_t rd_addr;
		logic                  rd_wena;
		rv_isa_pkg::inst_t     inst;
	} id_ex_t;

	// retired instruction, also the register file write port
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		logic                  rd_wena;
		rv_isa_pkg::reg_addr_t rd_addr;
		rv_isa_pkg::xlen_t     rd_data;
		rv_isa_pkg::inst_t     inst;
	} commit_t;

endpackage

/* source/regfile.sv */
`timescale 1ns/10ps

module regfile (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  rv_isa_pkg::reg_addr_t rs1_addr_i,
	input  rv_isa_pkg::reg_addr_t rs2_addr_i,
	output rv_isa_pkg::xlen_t     rs1_data_o,
	output rv_isa_pkg::xlen_t     rs2_data_o,
	input  rv_pipe_pkg::commit_t  wr_i
);

	// x0 has no storage
	rv_isa_pkg::xlen_t regs [1:31];
	logic              wr_en;

	assign wr_en = wr_i.valid && wr_i.rd_wena && (wr_i.rd_addr != '0);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_i.rd_addr] <= wr_i.rd_data;
		end
	end

	// same-cycle write shows through to the reader
	function automatic rv_isa_pkg::xlen_t read_port(input rv_isa_pkg::reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (wr_en && (wr_i.rd_addr == addr)) begin
			return wr_i.rd_data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs1_data_o = read_port(rs1_addr_i);
		rs2_data_o = read_port(rs2_addr_i);
	end

	a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		wr_i.valid && wr_i.rd_wena |-> wr_i.rd_addr != '0);

endmodule

/* source/id_stage.sv */
`timescale 1ns/10ps

module id_stage (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  inst_valid_i,
	input  rv_isa_pkg::inst_t     inst_i,
	input  rv_isa_pkg::xlen_t     rs1_data_i,
	input  rv_isa_pkg::xlen_t     rs2_data_i,
	output rv_isa_pkg::reg_addr_t rs1_addr_o,
	output rv_isa_pkg::reg_addr_t rs2_addr_o,
	output rv_pipe_pkg::id_ex_t   id_ex_o
);

	rv_isa_pkg::inst_u   inst;
	rv_pipe_pkg::id_ex_t dec;
	rv_pipe_pkg::id_ex_t id_ex_q;
	logic                valid_q;
	logic                is_op;
	logic                is_op_imm;
	logic                is_shift;
	logic                alt;
	logic                funct7_ok;

	assign inst      = inst_i;
	assign is_op     = (inst.r.opcode == rv_isa_pkg::OPC_OP);
	assign is_op_imm = (inst.i.opcode == rv_isa_pkg::OPC_OP_IMM);
	assign alt       = inst.r.funct7[rv_isa_pkg::F7_ALT_BIT];
	assign is_shift  = (inst.i.funct3 == rv_isa_pkg::F3_SLL) ||
		(inst.i.funct3 == rv_isa_pkg::F3_SRL_SRA);

	// rs2 only exists in the R-type view
	assign rs1_addr_o = inst.r.rs1;
	assign rs2_addr_o = is_op ? inst.r.rs2 : '0;

	// unknown opcodes never reach funct7_ok
	always_comb begin
		funct7_ok = 1'b0;
		if (is_op) begin
			funct7_ok = (inst.r.funct7 == rv_isa_pkg::F7_BASE) ||
				((inst.r.funct7 == rv_isa_pkg::F7_ALT) &&
				((inst.r.funct3 == rv_isa_pkg::F3_ADD_SUB) ||
				(inst.r.funct3 == rv_isa_pkg::F3_SRL_SRA)));
		end else if (is_op_imm) begin
			// low funct7 bit is shamt[5] on RV64
			funct7_ok = !is_shift ||
				(inst.r.funct7[6:1] == rv_isa_pkg::F7_BASE[6:1]) ||
				((inst.r.funct3 == rv_isa_pkg::F3_SRL_SRA) &&
				(inst.r.funct7[6:1] == rv_isa_pkg::F7_ALT[6:1]));
		end
	end

	always_comb begin
		dec          = '0;
		dec.valid    = inst_valid_i;
		dec.illegal  = !funct7_ok;
		dec.use_imm  = is_op_imm;
		dec.rs1_addr = rs1_addr_o;
		dec.rs2_addr = rs2_addr_o;
		dec.rs1_data = rs1_data_i;
		dec.rs2_data = rs2_data_i;
		dec.rd_addr  = inst.r.rd;
		dec.rd_wena  = funct7_ok && (inst.r.rd != '0);
		dec.inst     = inst_i;
		dec.imm      = {{(rv_isa_pkg::xlen - 12){inst.i.imm12[11]}}, inst.i.imm12};
		if (is_op_imm && is_shift) begin
			dec.imm = rv_isa_pkg::xlen_t'(inst.i.imm12[rv_isa_pkg::shamt_w-1:0]);
		end
		case (inst.r.funct3)
			// bit 30 is immediate data for ADDI
			rv_isa_pkg::F3_ADD_SUB: dec.alu_op = (is_op && alt) ? rv_pipe_pkg::ALU_SUB :
				rv_pipe_pkg::ALU_ADD;
			rv_isa_pkg::F3_SLL:     dec.alu_op = rv_pipe_pkg::ALU_SLL;
			rv_isa_pkg::F3_SLT:     dec.alu_op = rv_pipe_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU:    dec.alu_op = rv_pipe_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR:     dec.alu_op = rv_pipe_pkg::ALU_XOR;
			rv_isa_pkg::F3_SRL_SRA: dec.alu_op = alt ? rv_pipe_pkg::ALU_SRA : rv_pipe_pkg::ALU_SRL;
			rv_isa_pkg::F3_OR:      dec.alu_op = rv_pipe_pkg::ALU_OR;
			rv_isa_pkg::F3_AND:     dec.alu_op = rv_pipe_pkg::ALU_AND;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= inst_valid_i;
		end
	end

	// payload only moves with a strobe
	always_ff @(posedge clk) begin
		if (inst_valid_i) begin
			id_ex_q <= dec;
		end
	end

	always_comb begin
		id_ex_o       = id_ex_q;
		id_ex_o.valid = valid_q;
	end

	// x0 must read back as zero from the register file
	a_x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
		((rs1_addr_o != '0) || (rs1_data_i == '0)) &&
		((rs2_addr_o != '0) || (rs2_data_i == '0)));

endmodule

/* source/exe_stage.sv */
`timescale 1ns/10ps

module exe_stage (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  rv_pipe_pkg::id_ex_t  id_ex_i,
	output rv_pipe_pkg::commit_t commit_o
);

	rv_isa_pkg::xlen_t              op1;
	rv_isa_pkg::xlen_t              rs2_val;
	rv_isa_pkg::xlen_t              op2;
	rv_isa_pkg::xlen_t              result;
	logic [rv_isa_pkg::shamt_w-1:0] shamt;
	rv_pipe_pkg::commit_t           nxt;
	rv_pipe_pkg::commit_t           commit_q;
	logic                           valid_q;

	// take the value from the instruction one stage ahead if it writes addr
	function automatic rv_isa_pkg::xlen_t fwd(
		input rv_isa_pkg::reg_addr_t addr,
		input rv_isa_pkg::xlen_t     data,
		input rv_pipe_pkg::commit_t  ahead
	);
		if (ahead.valid && ahead.rd_wena && (addr != '0) && (ahead.rd_addr == addr)) begin
			return ahead.rd_data;
		end
		return data;
	endfunction

	assign op1     = fwd(id_ex_i.rs1_addr, id_ex_i.rs1_data, commit_o);
	assign rs2_val = fwd(id_ex_i.rs2_addr, id_ex_i.rs2_data, commit_o);
	assign op2     = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;
	assign shamt   = op2[rv_isa_pkg::shamt_w-1:0];

	always_comb begin
		case (id_ex_i.alu_op)
			rv_pipe_pkg::ALU_ADD:  result = op1 + op2;
			rv_pipe_pkg::ALU_SUB:  result = op1 - op2;
			rv_pipe_pkg::ALU_SLL:  result = op1 << shamt;
			rv_pipe_pkg::ALU_SLT:  result = {{(rv_isa_pkg::xlen - 1){1'b0}},
				$signed(op1) < $signed(op2)};
			rv_pipe_pkg::ALU_SLTU: result = {{(rv_isa_pkg::xlen - 1){1'b0}}, op1 < op2};
			rv_pipe_pkg::ALU_XOR:  result = op1 ^ op2;
			rv_pipe_pkg::ALU_SRL:  result = op1 >> shamt;
			// sign fill from bit 63
			rv_pipe_pkg::ALU_SRA:  result = $signed(op1) >>> shamt;
			rv_pipe_pkg::ALU_OR:   result = op1 | op2;
			rv_pipe_pkg::ALU_AND:  result = op1 & op2;
			default:               result = '0;
		endcase
	end

	always_comb begin
		nxt         = '0;
		nxt.valid   = id_ex_i.valid;
		nxt.illegal = id_ex_i.illegal;
		nxt.rd_wena = id_ex_i.rd_wena;
		nxt.rd_addr = id_ex_i.rd_addr;
		nxt.rd_data = result;
		nxt.inst    = id_ex_i.inst;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= id_ex_i.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (id_ex_i.valid) begin
			commit_q <= nxt;
		end
	end

	// valid for exactly one cycle per retired instruction
	always_comb begin
		commit_o       = commit_q;
		commit_o.valid = valid_q;
	end

	a_illegal_no_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		commit_o.valid && commit_o.illegal |-> !commit_o.rd_wena);

endmodule

/* source/rv_core.sv */
`timescale 1ns/10ps

module rv_core (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 inst_valid_i,
	input  rv_isa_pkg::inst_t    inst_i,
	output rv_pipe_pkg::commit_t commit_o
);

	rv_isa_pkg::reg_addr_t rs1_addr;
	rv_isa_pkg::reg_addr_t rs2_addr;
	rv_isa_pkg::xlen_t     rs1_data;
	rv_isa_pkg::xlen_t     rs2_data;
	rv_pipe_pkg::id_ex_t   id_ex;

	id_stage id_stage_i (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.inst_valid_i(inst_valid_i),
		.inst_i(inst_i),
		.rs1_data_i(rs1_data),
		.rs2_data_i(rs2_data),
		.rs1_addr_o(rs1_addr),
		.rs2_addr_o(rs2_addr),
		.id_ex_o(id_ex)
	);

	// written from the commit register, read during decode
	regfile regfile_i (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.rs1_addr_i(rs1_addr),
		.rs2_addr_i(rs2_addr),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data),
		.wr_i(commit_o)
	);

	exe_stage exe_stage_i (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.id_ex_i(id_ex),
		.commit_o(commit_o)
	);

endmodule

/* verif/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o;
	end

	// reset held for 8 cycles, released on a falling edge
	initial begin
		arst_n_o = 1'b0;
		repeat (8) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;
	end

endmodule

/* verif/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;

	// gap before an entry
	localparam logic [1:0] g_rand  = 2'd0;
	localparam logic [1:0] g_chain = 2'd1;
	localparam logic [1:0] g_one   = 2'd2;

	typedef struct packed {
		logic [1:0]           gap;
		rv_pipe_pkg::commit_t exp;
	} entry_t;

	logic                 clk;
	logic                 arst_n;
	logic                 inst_valid_i;
	rv_isa_pkg::inst_t    inst_i;
	rv_pipe_pkg::commit_t commit_o;

	entry_t tests [$];
	string  names [$];
	int     sent_cycle [$];
	int     sent_idx [$];
	int     cycle = 0;
	int     n_done = 0;
	int     passes = 0;
	int     errors = 0;

	tb_clkgen clkgen_i (
		.clk_o(clk),
		.arst_n_o(arst_n)
	);

	rv_core dut_i (
		.clk(clk),
		.arst_n_i(arst_n),
		.inst_valid_i(inst_valid_i),
		.inst_i(inst_i),
		.commit_o(commit_o)
	);

	function automatic rv_isa_pkg::inst_t itype(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
	endfunction

	function automatic rv_isa_pkg::inst_t rtype(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
	endfunction

	task automatic add_test(input string name, input logic [1:0] gap,
		input rv_isa_pkg::inst_t inst, input logic illegal, input logic wena,
		input rv_isa_pkg::xlen_t data);
		entry_t e;
		e             = '0;
		e.gap         = gap;
		e.exp.valid   = 1'b1;
		e.exp.illegal = illegal;
		e.exp.rd_wena = wena;
		e.exp.rd_addr = inst[11:7];
		e.exp.rd_data = data;
		e.exp.inst    = inst;
		tests.push_back(e);
		names.push_back(name);
	endtask

	task automatic fill_table();
		// known operands: x1 = 100, x2 = -7, x3 = 0x7ff
		add_test("addi_x1",    g_rand,  itype(3'd0, 5'd1, 5'd0, 12'd100), 1'b0, 1'b1, 64'h64);
		add_test("addi_neg",   g_rand,  itype(3'd0, 5'd2, 5'd0, 12'hff9), 1'b0, 1'b1,
			64'hffff_ffff_ffff_fff9);
		add_test("addi_x3",    g_rand,  itype(3'd0, 5'd3, 5'd0, 12'h7ff), 1'b0, 1'b1, 64'h7ff);
		add_test("slti",       g_rand,  itype(3'd2, 5'd4, 5'd2, 12'd1), 1'b0, 1'b1, 64'h1);
		add_test("sltiu_neg",  g_rand,  itype(3'd3, 5'd5, 5'd1, 12'hfff), 1'b0, 1'b1, 64'h1);
		add_test("xori",       g_rand,  itype(3'd4, 5'd6, 5'd1, 12'h0f0), 1'b0, 1'b1, 64'h94);
		add_test("ori",        g_rand,  itype(3'd6, 5'd7, 5'd1, 12'd3), 1'b0, 1'b1, 64'h67);
		add_test("andi",       g_rand,  itype(3'd7, 5'd8, 5'd3, 12'h0f0), 1'b0, 1'b1, 64'hf0);
		add_test("slli",       g_rand,  itype(3'd1, 5'd9, 5'd3, 12'd40), 1'b0, 1'b1,
			64'h0007_ff00_0000_0000);
		add_test("srli_neg",   g_rand,  itype(3'd5, 5'd10, 5'd2, 12'd60), 1'b0, 1'b1, 64'hf);
		add_test("srai_neg",   g_rand,  itype(3'd5, 5'd11, 5'd2, 12'h401), 1'b0, 1'b1,
			64'hffff_ffff_ffff_fffc);
		add_test("add",        g_rand,  rtype(7'h00, 3'd0, 5'd12, 5'd1, 5'd2), 1'b0, 1'b1, 64'h5d);
		add_test("sub",        g_rand,  rtype(7'h20, 3'd0, 5'd13, 5'd1, 5'd2), 1'b0, 1'b1, 64'h6b);
		add_test("sll",        g_rand,  rtype(7'h00, 3'd1, 5'd14, 5'd1, 5'd10), 1'b0, 1'b1,
			64'h32_0000);
		add_test("slt",        g_rand,  rtype(7'h00, 3'd2, 5'd15, 5'd2, 5'd1), 1'b0, 1'b1, 64'h1);
		add_test("sltu",       g_rand,  rtype(7'h00, 3'd3, 5'd16, 5'd2, 5'd1), 1'b0, 1'b1, 64'h0);
		add_test("xor",        g_rand,  rtype(7'h00, 3'd4, 5'd17, 5'd1, 5'd3), 1'b0, 1'b1, 64'h79b);
		add_test("srl",        g_rand,  rtype(7'h00, 3'd5, 5'd18, 5'd2, 5'd4), 1'b0, 1'b1,
			64'h7fff_ffff_ffff_fffc);
		add_test("sra",        g_rand,  rtype(7'h20, 3'd5, 5'd19, 5'd2, 5'd4), 1'b0, 1'b1,
			64'hffff_ffff_ffff_fffc);
		add_test("or",         g_rand,  rtype(7'h00, 3'd6, 5'd20, 5'd1, 5'd3), 1'b0, 1'b1, 64'h7ff);
		add_test("and",        g_rand,  rtype(7'h00, 3'd7, 5'd21, 5'd1, 5'd3), 1'b0, 1'b1, 64'h64);
		// back to back hits forwarding, a gap of one hits the regfile bypass
		add_test("fwd_base",   g_rand,  itype(3'd0, 5'd22, 5'd0, 12'd5), 1'b0, 1'b1, 64'h5);
		add_test("fwd_exe",    g_chain, rtype(7'h00, 3'd0, 5'd23, 5'd22, 5'd22), 1'b0, 1'b1, 64'ha);
		add_test("fwd_both",   g_chain, rtype(7'h20, 3'd0, 5'd24, 5'd23, 5'd22), 1'b0, 1'b1, 64'h5);
		add_test("bypass",     g_one,   itype(3'd0, 5'd25, 5'd24, 12'd1), 1'b0, 1'b1, 64'h6);
		add_test("bypass_xor", g_one,   rtype(7'h00, 3'd4, 5'd26, 5'd25, 5'd24), 1'b0, 1'b1, 64'h3);
		add_test("x0_write",   g_rand,  itype(3'd0, 5'd0, 5'd1, 12'd55), 1'b0, 1'b0, 64'h0);
		add_test("x0_read",    g_chain, rtype(7'h00, 3'd0, 5'd27, 5'd0, 5'd1), 1'b0, 1'b1, 64'h64);
		// ld x1, 0(x2)
		add_test("ill_load",   g_rand,  32'h0001_3083, 1'b1, 1'b0, 64'h0);
		add_test("after_load", g_chain, rtype(7'h00, 3'd0, 5'd28, 5'd1, 5'd0), 1'b0, 1'b1, 64'h64);
		add_test("ill_funct7", g_rand,  rtype(7'h01, 3'd0, 5'd3, 5'd1, 5'd2), 1'b1, 1'b0, 64'h0);
		add_test("after_f7",   g_chain, rtype(7'h00, 3'd6, 5'd29, 5'd3, 5'd0), 1'b0, 1'b1, 64'h7ff);
	endtask

	// rd_data is left to check_word
	task automatic check_commit(input string name, input rv_pipe_pkg::commit_t exp,
		input rv_pipe_pkg::commit_t act, output bit ok);
		rv_pipe_pkg::commit_t e;
		rv_pipe_pkg::commit_t a;
		e         = exp;
		a         = act;
		e.rd_data = '0;
		a.rd_data = '0;
		ok        = (a === e);
		if (!ok) begin
			$display("FAIL %s commit expected %h actual %h", name, e, a);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input rv_isa_pkg::xlen_t exp,
		input rv_isa_pkg::xlen_t act, output bit ok);
		ok = (act === exp);
		if (!ok) begin
			$display("FAIL %s rd_data expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic send_all();
		int gap;
		@(posedge arst_n);
		@(negedge clk);
		foreach (tests[t]) begin
			case (tests[t].gap)
				g_chain: gap = 0;
				g_one:   gap = 1;
				default: gap = int'($urandom % 3);
			endcase
			inst_valid_i = 1'b0;
			repeat (gap) @(negedge clk);
			inst_valid_i = 1'b1;
			inst_i       = tests[t].exp.inst;
			sent_cycle.push_back(cycle);
			sent_idx.push_back(t);
			@(negedge clk);
		end
		inst_valid_i = 1'b0;
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// commit_o is stable at the falling edge
	always @(negedge clk) begin : monitor
		int idx;
		int when;
		bit ok;
		if (commit_o.valid && sent_idx.size() == 0) begin
			$display("commit_o valid with no instruction outstanding at cycle %0d", cycle);
			errors++;
		end else if (commit_o.valid) begin
			idx  = sent_idx.pop_front();
			when = sent_cycle.pop_front();
			if (cycle != when + 2) begin
				$display("%s retired %0d cycles after its strobe", names[idx], cycle - when);
				errors++;
			end else begin
				check_commit(names[idx], tests[idx].exp, commit_o, ok);
				if (ok && tests[idx].exp.rd_wena) begin
					check_word(names[idx], tests[idx].exp.rd_data, commit_o.rd_data, ok);
				end
				if (ok) begin
					$display("ok   %s", names[idx]);
					passes++;
				end
			end
			n_done++;
		end else if (sent_cycle.size() != 0 && cycle >= sent_cycle[0] + 2) begin
			idx  = sent_idx.pop_front();
			when = sent_cycle.pop_front();
			$display("%s sent at cycle %0d never retired on commit_o", names[idx], when);
			errors++;
			n_done++;
		end
	end

	initial begin : main
		int limit;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		void'($urandom(32'he0173b15));
		fill_table();
		limit = tests.size() * 5 + 40;
		fork
			send_all();
		join_none
		while (n_done < tests.size() && cycle < limit) begin
			@(negedge clk);
		end
		if (n_done < tests.size()) begin
			$display("timeout at cycle %0d with %0d of %0d tests retired", cycle, n_done,
				tests.size());
			errors++;
		end
		$display("%0d tests, %0d passed, %0d errors", tests.size(), passes, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/regfile.sv
source/id_stage.sv
source/exe_stage.sv
source/rv_core.sv
verif/tb_clkgen.sv
verif/tb_rv_core.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --assert --timescale 1ns/10ps --top-module tb_rv_core \
	-Mdir build/obj_dir -f files.f

./build/obj_dir/Vtb_rv_core > build/sim.log 2>&1 || true
cat build/sim.log

if grep -q "CHECKS FAILED" build/sim.log || ! grep -q "ALL CHECKS PASSED" build/sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
